// ==== verilog.f ====
verilog/norm_check_pkg.sv
verilog/norm_check.sv
verilog/norm_check_ctrl.sv
verilog/norm_check_result.sv
verilog/norm_check_top.sv
verif/tb_clock_gen.sv
verif/norm_check_tb.sv

// ==== Makefile ====
# Verilator build and run of the norm check testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= norm_check_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG := TB FAILED
PASS_MSG := TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Result: fail"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: no result line in $(LOG)"; exit 1; \
	else \
		echo "Result: pass"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/norm_check_testdata.hex ====
// mode(0 z,1 r0,2 ct0) shuffle seed base opt(1 plant,2 keep memory,4 zeroize)
// plant_word_addr plant_lane plant_value expected_invalid
0 0 00 000 0 000 0 000000 0
1 0 00 100 0 000 0 000000 0
2 0 00 200 0 000 0 000000 0
0 0 00 000 1 005 2 07FF88 1
0 0 00 000 1 1BF 3 77E079 1
0 0 00 000 1 0A0 1 07FF87 0
1 0 00 100 1 100 0 03FE88 1
1 0 00 100 1 2FF 3 7BE179 1
1 0 00 100 1 180 2 03FE87 0
2 0 00 200 1 3FF 1 03FF00 1
2 0 00 200 1 233 0 7BE101 1
2 0 00 200 1 200 3 03FEFF 0
0 0 00 040 1 20A 2 400000 0
1 0 00 040 2 000 0 000000 1
1 1 2A 180 1 251 1 03FE88 1
2 1 3F 080 0 000 0 000000 0
0 0 00 000 5 000 0 07FF88 1
1 0 00 000 0 000 0 000000 0

// ==== verif/norm_check_tb.sv ====
`timescale 1ns/1ps

module norm_check_tb
    import norm_check_pkg::*;
();

    // Nine fields per record, see the header of the data file
    localparam int NUM_REC    = 18;
    localparam int FIELDS     = 9;
    localparam int TIMEOUT    = NUM_REC * 600 + 100;
    localparam int MEM_WORDS  = 1024;
    localparam int FILL_MAX   = 200000;
    localparam int ZEROIZE_AT = 50;
    localparam int DONE_SLACK = 8;

    // Option bits of a record
    localparam int OPT_PLANT   = 1;
    localparam int OPT_KEEP    = 2;
    localparam int OPT_ZEROIZE = 4;

    logic                                clk;
    logic                                reset_n;
    logic                                zeroize;
    logic                                norm_check_enable;
    chk_norm_mode_t                      mode;
    logic                                shuffling_enable;
    logic [WORD_IDX_WIDTH-1:0]           randomness;
    logic [MLDSA_MEM_ADDR_WIDTH-1:0]     mem_base_addr;
    mem_if_t                             mem_rd_req;
    logic [COEFFS_PER_WORD*REG_SIZE-1:0] mem_rd_data;
    logic                                invalid;
    logic                                norm_check_ready;
    logic                                norm_check_done;

    logic [31:0]                         testdata [0:NUM_REC*FIELDS-1];
    logic [COEFFS_PER_WORD*REG_SIZE-1:0] mem [0:MEM_WORDS-1];
    int                                  read_count [0:MEM_WORDS-1];
    integer                              seed;
    int                                  cycle_cnt = 0;

    tb_clock_gen u_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    norm_check_top uut (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .norm_check_enable (norm_check_enable),
        .mode              (mode),
        .shuffling_enable  (shuffling_enable),
        .randomness        (randomness),
        .mem_base_addr     (mem_base_addr),
        .mem_rd_req        (mem_rd_req),
        .mem_rd_data       (mem_rd_data),
        .invalid           (invalid),
        .norm_check_ready  (norm_check_ready),
        .norm_check_done   (norm_check_done)
    );

    // Coefficient memory with a registered read, data one cycle after rd_en
    always @(posedge clk) begin
        if (mem_rd_req.rd_en) begin
            mem_rd_data <= mem[mem_rd_req.addr];
        end
    end

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // Global limit over all records
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout after %0d cycles without finishing the records", cycle_cnt);
            stop_with_failure();
        end
    end

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            stop_with_failure();
        end
    endtask

    task automatic compare_req(input string name, input mem_if_t got, input mem_if_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            stop_with_failure();
        end
    endtask

    // Signed value of a coefficient in the range -(q-1)/2 .. (q-1)/2
    function automatic int centered(input logic [COEFF_WIDTH-1:0] v);
        int s;
        s = int'(v);
        if (s > (MLDSA_Q - 1) / 2) begin
            s = s - MLDSA_Q;
        end
        return s;
    endfunction

    // A vector fails when any coefficient it covers reaches the bound in magnitude
    function automatic logic expected_flag(input int md, input int base);
        int   polys;
        int   bound;
        int   a;
        int   s;
        logic flag;
        polys = (md == 0) ? MLDSA_L : MLDSA_K;
        bound = (md == 0) ? Z_BOUND : ((md == 1) ? R0_BOUND : CT0_BOUND);
        flag  = 1'b0;
        for (int w = 0; w < polys * WORDS_PER_POLY; w++) begin
            a = (base + w) % MEM_WORDS;
            for (int ln = 0; ln < COEFFS_PER_WORD; ln++) begin
                s = centered(mem[a][ln*REG_SIZE +: COEFF_WIDTH]);
                if (s >= bound || s <= -bound) begin
                    flag = 1'b1;
                end
            end
        end
        return flag;
    endfunction

    // Random in-range coefficients, stored as c or q - c
    task automatic fill_memory();
        int          c;
        logic [31:0] sign_bits;
        for (int a = 0; a < MEM_WORDS; a++) begin
            for (int ln = 0; ln < COEFFS_PER_WORD; ln++) begin
                c = {$random(seed)} % FILL_MAX;
                sign_bits = $random(seed);
                if (sign_bits[0] && c != 0) begin
                    c = MLDSA_Q - c;
                end
                mem[a][ln*REG_SIZE +: REG_SIZE] = REG_SIZE'(c);
            end
        end
    endtask

    // Zeroize in the cycle after the current one, then everything must be low
    task automatic zeroize_mid_run();
        @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        @(negedge clk);
        compare_bit("mem_rd_req.rd_en", mem_rd_req.rd_en, 1'b0);
        compare_bit("norm_check_done", norm_check_done, 1'b0);
        compare_bit("norm_check_ready", norm_check_ready, 1'b0);
        compare_bit("invalid", invalid, 1'b0);
    endtask

    // One run from enable to ready; abort_at > 0 zeroizes in that cycle instead
    task automatic run_check(input int md, input int shf, input int r, input int base,
                             input logic exp_flag, input int abort_at);
        int      words;
        int      ofs;
        int      k;
        logic    done_seen;
        mem_if_t exp_req;
        words = ((md == 0) ? MLDSA_L : MLDSA_K) * WORDS_PER_POLY;
        ofs   = (shf != 0) ? r : 0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            read_count[a] = 0;
        end
        @(posedge clk);
        norm_check_enable <= 1'b1;
        mode              <= chk_norm_mode_t'(2'(md));
        shuffling_enable  <= (shf != 0);
        randomness        <= WORD_IDX_WIDTH'(r);
        mem_base_addr     <= MLDSA_MEM_ADDR_WIDTH'(base);
        // This edge samples the enable, so the next negedge is cycle 1
        @(posedge clk);
        norm_check_enable <= 1'b0;
        k = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(negedge clk);
            k++;
            if (k <= words) begin
                // Polynomial from the cycle count, word rotated by the seed
                exp_req.rd_en = 1'b1;
                exp_req.addr  = MLDSA_MEM_ADDR_WIDTH'(base
                    + ((k - 1) / WORDS_PER_POLY) * WORDS_PER_POLY
                    + ((k - 1) % WORDS_PER_POLY + ofs) % WORDS_PER_POLY);
                compare_req("mem_rd_req", mem_rd_req, exp_req);
                read_count[mem_rd_req.addr]++;
            end else begin
                compare_bit("mem_rd_req.rd_en", mem_rd_req.rd_en, 1'b0);
            end
            compare_bit("norm_check_ready", norm_check_ready, 1'b0);
            if (abort_at > 0 && k == abort_at) begin
                zeroize_mid_run();
                return;
            end
            if (norm_check_done === 1'b1) begin
                done_seen = 1'b1;
            end else if (k > words + DONE_SLACK) begin
                $display("Done did not arrive within %0d cycles of the enable", k);
                stop_with_failure();
            end
        end
        if (k != words + 2) begin
            $display("Done arrived in cycle %0d instead of cycle %0d", k, words + 2);
            stop_with_failure();
        end
        compare_bit("invalid", invalid, exp_flag);
        for (int w = 0; w < words; w++) begin
            if (read_count[(base + w) % MEM_WORDS] != 1) begin
                $display("Word %0d of the vector was read %0d times", w,
                         read_count[(base + w) % MEM_WORDS]);
                stop_with_failure();
            end
        end
        // Ready follows one cycle later with the flag already cleared
        @(negedge clk);
        compare_bit("norm_check_ready", norm_check_ready, 1'b1);
        compare_bit("norm_check_done", norm_check_done, 1'b0);
        compare_bit("invalid", invalid, 1'b0);
    endtask

    initial begin
        int   md;
        int   shf;
        int   sd;
        int   base;
        int   opt;
        int   waddr;
        int   lane;
        int   value;
        logic exp_rec;
        logic exp_ref;
        seed              = 32'hcdd5387d;
        zeroize           = 1'b0;
        norm_check_enable = 1'b0;
        mode              = CHK_Z;
        shuffling_enable  = 1'b0;
        randomness        = '0;
        mem_base_addr     = '0;
        mem_rd_data       = '0;
        $readmemh("verif/norm_check_testdata.hex", testdata);
        if ($isunknown(testdata[NUM_REC*FIELDS-1])) begin
            $display("The test data file is missing or has too few records");
            stop_with_failure();
        end
        wait (reset_n === 1'b1);
        for (int i = 0; i < NUM_REC; i++) begin
            md      = int'(testdata[i*FIELDS + 0]);
            shf     = int'(testdata[i*FIELDS + 1]);
            sd      = int'(testdata[i*FIELDS + 2]);
            base    = int'(testdata[i*FIELDS + 3]);
            opt     = int'(testdata[i*FIELDS + 4]);
            waddr   = int'(testdata[i*FIELDS + 5]);
            lane    = int'(testdata[i*FIELDS + 6]);
            value   = int'(testdata[i*FIELDS + 7]);
            exp_rec = testdata[i*FIELDS + 8][0];
            // Keeping memory lets a second mode look at the same vector
            if ((opt & OPT_KEEP) == 0) begin
                fill_memory();
            end
            if ((opt & OPT_PLANT) != 0) begin
                mem[waddr][lane*REG_SIZE +: REG_SIZE] = REG_SIZE'(value);
            end
            exp_ref = expected_flag(md, base);
            if (exp_ref !== exp_rec) begin
                $display("Record %0d expects flag %0b but the bound rule gives %0b",
                         i, exp_rec, exp_ref);
                stop_with_failure();
            end
            if ((opt & OPT_ZEROIZE) != 0) begin
                run_check(md, shf, sd, base, exp_ref, ZEROIZE_AT);
            end
            run_check(md, shf, sd, base, exp_ref, 0);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    // 10 ns period
    localparam real HALF_PERIOD = 5.0;
    localparam int  RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset is released on a rising edge, like any other driven input
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

// ==== verilog/norm_check_top.sv ====
`timescale 1ns/1ps

module norm_check_top
    import norm_check_pkg::*;
(
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize,

    // Host request, valid in the enable cycle only
    input  logic                                norm_check_enable,
    input  chk_norm_mode_t                      mode,
    input  logic                                shuffling_enable,
    input  logic [WORD_IDX_WIDTH-1:0]           randomness,
    input  logic [MLDSA_MEM_ADDR_WIDTH-1:0]     mem_base_addr,

    // Coefficient memory, fixed one-cycle read latency
    output mem_if_t                             mem_rd_req,
    input  logic [COEFFS_PER_WORD*REG_SIZE-1:0] mem_rd_data,

    // Result toward the host
    output logic                                invalid,
    output logic                                norm_check_ready,
    output logic                                norm_check_done
);

    // Mode held for the whole run
    chk_norm_mode_t active_mode;

    // Sequencer strobes
    logic check_enable;
    logic check_done;

    // Enable aligned with the returning memory word
    logic check_enable_q;

    // One flag per coefficient lane
    logic [COEFFS_PER_WORD-1:0] lane_invalid;

    // Address generation over the whole vector
    norm_check_ctrl u_ctrl (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .norm_check_enable (norm_check_enable),
        .mode              (mode),
        .shuffling_enable  (shuffling_enable),
        .randomness        (randomness),
        .mem_base_addr     (mem_base_addr),
        .mem_rd_req        (mem_rd_req),
        .active_mode       (active_mode),
        .check_enable      (check_enable),
        .check_done        (check_done)
    );

    // Four parallel checks, one per coefficient in the word
    // Lane i sees bits 24i to 24i+22, the top bit of each slot is unused
    for (genvar i = 0; i < COEFFS_PER_WORD; i++) begin : g_lane
        norm_check u_check (
            .enable  (check_enable_q),
            .mode    (active_mode),
            .opa_i   (mem_rd_data[i*REG_SIZE +: COEFF_WIDTH]),
            .invalid (lane_invalid[i])
        );
    end

    // Flag accumulation and the done/ready handshake
    norm_check_result u_result (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .check_enable     (check_enable),
        .check_done       (check_done),
        .lane_invalid     (lane_invalid),
        .check_enable_q   (check_enable_q),
        .invalid          (invalid),
        .norm_check_done  (norm_check_done),
        .norm_check_ready (norm_check_ready)
    );

endmodule

// ==== verilog/norm_check_result.sv ====
`timescale 1ns/1ps

module norm_check_result
    import norm_check_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    input  logic                       check_enable,
    input  logic                       check_done,
    input  logic [COEFFS_PER_WORD-1:0] lane_invalid,
    output logic                       check_enable_q,
    output logic                       invalid,
    output logic                       norm_check_done,
    output logic                       norm_check_ready
);

    // Memory data returns one cycle after the request, so the enable
    // is delayed to line up with it
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            check_enable_q <= 1'b0;
        end else if (zeroize) begin
            check_enable_q <= 1'b0;
        end else begin
            check_enable_q <= check_enable;
        end
    end

    // Sticky flag over every coefficient of the vector
    // It is cleared once the host has seen it in the done cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            invalid <= 1'b0;
        end else if (zeroize || norm_check_done) begin
            invalid <= 1'b0;
        end else begin
            invalid <= invalid | (|lane_invalid);
        end
    end

    // Done follows the flush cycle, by which point the last lane results
    // are already in the flag
    // Ready comes one cycle later so the host can capture invalid first
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            norm_check_done  <= 1'b0;
            norm_check_ready <= 1'b0;
        end else if (zeroize) begin
            norm_check_done  <= 1'b0;
            norm_check_ready <= 1'b0;
        end else begin
            norm_check_done  <= check_done;
            norm_check_ready <= norm_check_done;
        end
    end

    a_done_ready_apart: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(norm_check_ready && norm_check_done)
    ) else $error("done and ready high in the same cycle");

endmodule

// ==== verilog/norm_check_ctrl.sv ====
`timescale 1ns/1ps

module norm_check_ctrl
    import norm_check_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize,
    input  logic                            norm_check_enable,
    input  chk_norm_mode_t                  mode,
    input  logic                            shuffling_enable,
    input  logic [WORD_IDX_WIDTH-1:0]       randomness,
    input  logic [MLDSA_MEM_ADDR_WIDTH-1:0] mem_base_addr,
    output mem_if_t                         mem_rd_req,
    output chk_norm_mode_t                  active_mode,
    output logic                            check_enable,
    output logic                            check_done
);

    ctrl_state_t state;

    // Request captured in the enable cycle
    logic [MLDSA_MEM_ADDR_WIDTH-1:0] base_q;
    logic [WORD_IDX_WIDTH-1:0]       seed_q;

    // Position inside the vector
    logic [POLY_IDX_WIDTH-1:0] poly_cnt;
    logic [WORD_IDX_WIDTH-1:0] word_cnt;

    // Last polynomial index for the latched mode
    logic [POLY_IDX_WIDTH-1:0] poly_last;
    // Rotated word offset inside the current polynomial
    logic [WORD_IDX_WIDTH-1:0] word_ofs;
    logic                      last_word;
    logic                      last_poly;

    // The z vector is shorter than r0 and ct0
    assign poly_last = (active_mode == CHK_Z) ? POLY_IDX_WIDTH'(MLDSA_L - 1)
                                              : POLY_IDX_WIDTH'(MLDSA_K - 1);

    // Wraps modulo 64, which gives the rotation of the shuffled order
    assign word_ofs  = word_cnt + seed_q;
    assign last_word = (word_cnt == WORD_IDX_WIDTH'(WORDS_PER_POLY - 1));
    assign last_poly = (poly_cnt == poly_last);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= CTRL_IDLE;
            active_mode <= CHK_Z;
            base_q      <= '0;
            seed_q      <= '0;
            poly_cnt    <= '0;
            word_cnt    <= '0;
        end else if (zeroize) begin
            state       <= CTRL_IDLE;
            active_mode <= CHK_Z;
            base_q      <= '0;
            seed_q      <= '0;
            poly_cnt    <= '0;
            word_cnt    <= '0;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    // Enables arriving while busy never reach this branch
                    if (norm_check_enable) begin
                        active_mode <= mode;
                        base_q      <= mem_base_addr;
                        seed_q      <= shuffling_enable ? randomness : '0;
                        poly_cnt    <= '0;
                        word_cnt    <= '0;
                        state       <= CTRL_READ;
                    end
                end
                CTRL_READ: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (last_word) begin
                        if (last_poly) begin
                            state <= CTRL_FLUSH;
                        end else begin
                            poly_cnt <= poly_cnt + 1'b1;
                        end
                    end
                end
                // One cycle for the last word to come back from memory
                CTRL_FLUSH: begin
                    state <= CTRL_IDLE;
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    // One word per cycle while reading
    // Address is base + 64*poly + rotated word offset
    assign mem_rd_req.rd_en = (state == CTRL_READ);
    assign mem_rd_req.addr  = base_q + MLDSA_MEM_ADDR_WIDTH'({poly_cnt, word_ofs});

    assign check_enable = mem_rd_req.rd_en;
    assign check_done   = (state == CTRL_FLUSH);

    a_no_read_in_idle: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(mem_rd_req.rd_en && state == CTRL_IDLE)
    ) else $error("read request issued while sequencer is idle");

    a_done_one_cycle: assert property (
        @(posedge clk) disable iff (!reset_n)
        check_done |=> !check_done
    ) else $error("check_done held for more than one cycle");

endmodule

// ==== verilog/norm_check.sv ====
`timescale 1ns/1ps

module norm_check
    import norm_check_pkg::*;
(
    input  logic                   enable,
    input  chk_norm_mode_t         mode,
    input  logic [COEFF_WIDTH-1:0] opa_i,
    output logic                   invalid
);

    // Centered magnitude of the coefficient
    logic [COEFF_WIDTH-1:0] mag;
    // Bound of the active mode
    logic [COEFF_WIDTH-1:0] bound;

    // A coefficient above (q-1)/2 stands for a negative value, so its
    // magnitude is q minus the stored value
    // Stored values at or above q wrap to a large magnitude and get flagged
    always_comb begin
        if (opa_i > COEFF_WIDTH'(HALF_Q)) begin
            mag = COEFF_WIDTH'(MLDSA_Q) - opa_i;
        end else begin
            mag = opa_i;
        end
    end

    // Pick the bound for the vector under test
    always_comb begin
        case (mode)
            CHK_Z:   bound = COEFF_WIDTH'(Z_BOUND);
            CHK_R0:  bound = COEFF_WIDTH'(R0_BOUND);
            CHK_CT0: bound = COEFF_WIDTH'(CT0_BOUND);
            // Unused encoding gets the tightest bound
            default: bound = COEFF_WIDTH'(R0_BOUND);
        endcase
    end

    // The norm check is strict, so a magnitude equal to the bound fails
    // Enable masks lanes that carry no valid read data
    assign invalid = enable && (mag >= bound);

endmodule

// ==== verilog/norm_check_pkg.sv ====
package norm_check_pkg;

    // ML-DSA modulus and polynomial geometry
    localparam int MLDSA_Q = 8380417;
    localparam int MLDSA_N = 256;

    // Vector lengths for ML-DSA-87
    // The z vector has L polynomials and the r0 and ct0 vectors have K
    localparam int MLDSA_L = 7;
    localparam int MLDSA_K = 8;

    // Each coefficient sits in a 24-bit slot, of which the low 23 bits carry the value
    localparam int REG_SIZE = 24;
    localparam int COEFF_WIDTH = REG_SIZE - 1;

    // Four coefficients share one memory word
    localparam int COEFFS_PER_WORD = 4;
    localparam int WORDS_PER_POLY = MLDSA_N / COEFFS_PER_WORD;

    // Counter widths for the word index inside a polynomial and the polynomial index
    localparam int WORD_IDX_WIDTH = $clog2(WORDS_PER_POLY);
    localparam int POLY_IDX_WIDTH = $clog2(MLDSA_K);

    localparam int MLDSA_MEM_ADDR_WIDTH = 10;

    // Norm bounds for the three checks of the signing loop
    // gamma1 - beta for z
    localparam int Z_BOUND = 524168;
    // gamma2 - beta for r0
    localparam int R0_BOUND = 261768;
    // gamma2 for ct0
    localparam int CT0_BOUND = 261888;

    // Values above this are negative numbers in the centered representation
    localparam int HALF_Q = (MLDSA_Q - 1) / 2;

    // Which vector is being checked and therefore which bound applies
    typedef enum logic [1:0] {
        CHK_Z   = 2'd0,
        CHK_R0  = 2'd1,
        CHK_CT0 = 2'd2
    } chk_norm_mode_t;

    // Sequencer states
    // FLUSH covers the cycle in which the last read data returns
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,
        CTRL_READ  = 2'd1,
        CTRL_FLUSH = 2'd2
    } ctrl_state_t;

    // Read request toward the coefficient memory
    // Data comes back one cycle after rd_en
    typedef struct packed {
        logic                            rd_en;
        logic [MLDSA_MEM_ADDR_WIDTH-1:0] addr;
    } mem_if_t;

endpackage
